//--- common/tcdm_defs.svh
//****************************************
// tcdm subsystem parameters
// widths, master count and memory sizes
//****************************************

`ifndef TCDM_DEFS_SVH
`define TCDM_DEFS_SVH

// byte address that covers the whole bank
`define TCDM_ADDR_WIDTH 12

// one bank word
`define TCDM_DATA_WIDTH 32

// peer masters sharing the bank
`define TCDM_NUM_MASTERS 2

// words in the bank
`define TCDM_MEM_WORDS 1024

// response entries per converter
`define TCDM_BUF_DEPTH 2

`endif

//--- common/reqrsp_pkg.sv
//****************************************
// reqrsp port types
// request and response channels, atomics
//****************************************

`include "tcdm_defs.svh"

package reqrsp_pkg;

  typedef enum logic [1:0] {
    AmoNone = 2'd0,
    AmoSwap = 2'd1,
    AmoAdd  = 2'd2
  } amo_op_e;

  typedef struct packed {
    logic [`TCDM_ADDR_WIDTH-1:0]   addr;
    logic                          write;
    amo_op_e                       amo;
    logic [`TCDM_DATA_WIDTH-1:0]   data;
    logic [`TCDM_DATA_WIDTH/8-1:0] strb;  // one bit per byte lane
  } reqrsp_q_t;

  typedef struct packed {
    logic [`TCDM_DATA_WIDTH-1:0] data;
  } reqrsp_p_t;

  typedef struct packed {
    reqrsp_q_t q;
    logic      q_valid;
    logic      p_ready;
  } reqrsp_req_t;

  typedef struct packed {
    reqrsp_p_t p;
    logic      p_valid;
    logic      q_ready;
  } reqrsp_rsp_t;

endpackage

//--- common/tcdm_pkg.sv
//****************************************
// tcdm port types
// request with handshake, fixed response
//****************************************

`include "tcdm_defs.svh"

package tcdm_pkg;

  import reqrsp_pkg::amo_op_e;

  typedef struct packed {
    logic [`TCDM_ADDR_WIDTH-1:0]   addr;
    logic                          write;
    amo_op_e                       amo;
    logic [`TCDM_DATA_WIDTH-1:0]   data;
    logic [`TCDM_DATA_WIDTH/8-1:0] strb;
  } tcdm_q_t;

  typedef struct packed {
    tcdm_q_t q;
    logic    q_valid;
  } tcdm_req_t;

  // the response has no ready and always arrives one cycle after the request
  typedef struct packed {
    logic [`TCDM_DATA_WIDTH-1:0] p_data;
    logic                        p_valid;
    logic                        q_ready;
  } tcdm_rsp_t;

endpackage

//--- reqrsp_to_tcdm/reqrsp_to_tcdm.sv
//****************************************
// reqrsp_to_tcdm
// reqrsp port to tcdm port converter with
// credit count and response buffer
//****************************************

`timescale 1ns/100ps

`include "tcdm_defs.svh"

module reqrsp_to_tcdm (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  reqrsp_pkg::reqrsp_req_t reqrsp_req_i,
  output reqrsp_pkg::reqrsp_rsp_t reqrsp_rsp_o,
  output tcdm_pkg::tcdm_req_t     tcdm_req_o,
  input  tcdm_pkg::tcdm_rsp_t     tcdm_rsp_i
);

  localparam int unsigned Depth = `TCDM_BUF_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  logic [CntW-1:0]             credit_q;  // in flight plus buffered responses
  logic [CntW-1:0]             fill_q;
  logic [PtrW-1:0]             wr_ptr_q;
  logic [PtrW-1:0]             rd_ptr_q;
  logic [`TCDM_DATA_WIDTH-1:0] fifo_mem [Depth];
  logic                        has_room;
  logic                        q_fire;
  logic                        p_fire;
  logic                        rsp_valid;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    logic [PtrW-1:0] nxt;
    nxt = (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  // a request is only let through when its response has a slot waiting
  assign has_room = credit_q < CntW'(Depth);

  assign tcdm_req_o.q = '{
    addr:  reqrsp_req_i.q.addr,
    write: reqrsp_req_i.q.write,
    amo:   reqrsp_req_i.q.amo,
    data:  reqrsp_req_i.q.data,
    strb:  reqrsp_req_i.q.strb
  };
  assign tcdm_req_o.q_valid   = reqrsp_req_i.q_valid & has_room;
  assign reqrsp_rsp_o.q_ready = tcdm_rsp_i.q_ready & has_room;

  assign q_fire    = tcdm_req_o.q_valid & tcdm_rsp_i.q_ready;
  assign rsp_valid = (fill_q != '0);
  assign p_fire    = rsp_valid & reqrsp_req_i.p_ready;

  assign reqrsp_rsp_o.p_valid = rsp_valid;
  assign reqrsp_rsp_o.p.data  = fifo_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= '0;
      fill_q   <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      credit_q <= credit_q + CntW'(q_fire) - CntW'(p_fire);
      fill_q   <= fill_q + CntW'(tcdm_rsp_i.p_valid) - CntW'(p_fire);
      if (tcdm_rsp_i.p_valid) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (p_fire) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
    end
  end

  // credits guarantee a free entry for every response
  always_ff @(posedge clk_i) begin
    if (tcdm_rsp_i.p_valid) begin
      fifo_mem[wr_ptr_q] <= tcdm_rsp_i.p_data;
    end
  end

endmodule

//--- verilog/tcdm_arbiter.sv
//****************************************
// tcdm_arbiter
// round-robin sharing of one tcdm bank
//****************************************

`timescale 1ns/100ps

`include "tcdm_defs.svh"

module tcdm_arbiter (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  tcdm_pkg::tcdm_req_t mst_req_i [`TCDM_NUM_MASTERS],
  output tcdm_pkg::tcdm_rsp_t mst_rsp_o [`TCDM_NUM_MASTERS],
  output tcdm_pkg::tcdm_req_t bank_req_o,
  input  tcdm_pkg::tcdm_rsp_t bank_rsp_i
);

  localparam int unsigned NumMst = `TCDM_NUM_MASTERS;
  localparam int unsigned IdxW   = (NumMst > 1) ? $clog2(NumMst) : 1;
  localparam int unsigned CandW  = IdxW + 1;

  logic [IdxW-1:0]  rr_q;     // first master to look at
  logic [IdxW-1:0]  gnt_q;    // owner of the response in this cycle
  logic [IdxW-1:0]  gnt_idx;
  logic [IdxW-1:0]  rr_next;
  logic [CandW-1:0] cand;
  logic             gnt_valid;
  logic             bank_fire;

  always_comb begin
    gnt_valid = 1'b0;
    gnt_idx   = rr_q;
    cand      = '0;
    for (int unsigned i = 0; i < NumMst; i++) begin
      cand = CandW'(rr_q) + CandW'(i);
      if (cand >= CandW'(NumMst)) begin
        cand = cand - CandW'(NumMst);
      end
      if (!gnt_valid && mst_req_i[cand[IdxW-1:0]].q_valid) begin
        gnt_valid = 1'b1;
        gnt_idx   = cand[IdxW-1:0];
      end
    end
  end

  // with no valid request the selected entry has q_valid low as well
  assign bank_req_o = mst_req_i[gnt_idx];
  assign bank_fire  = gnt_valid & bank_rsp_i.q_ready;
  assign rr_next    = (gnt_idx == IdxW'(NumMst - 1)) ? '0 : gnt_idx + 1'b1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q  <= '0;
      gnt_q <= '0;
    end else if (bank_fire) begin
      rr_q  <= rr_next;
      gnt_q <= gnt_idx;
    end
  end

  for (genvar m = 0; m < NumMst; m++) begin : g_rsp
    assign mst_rsp_o[m].p_data  = bank_rsp_i.p_data;
    assign mst_rsp_o[m].p_valid = bank_rsp_i.p_valid & (gnt_q == IdxW'(m));
    assign mst_rsp_o[m].q_ready = bank_rsp_i.q_ready & gnt_valid & (gnt_idx == IdxW'(m));
  end

endmodule

//--- verilog/tcdm_bank.sv
//****************************************
// tcdm_bank
// single-ported memory, strobed writes,
// swap and add atomics
//****************************************

`timescale 1ns/100ps

`include "tcdm_defs.svh"

module tcdm_bank (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  tcdm_pkg::tcdm_req_t tcdm_req_i,
  output tcdm_pkg::tcdm_rsp_t tcdm_rsp_o
);

  import reqrsp_pkg::*;

  localparam int unsigned DataW    = `TCDM_DATA_WIDTH;
  localparam int unsigned NumBytes = DataW / 8;
  localparam int unsigned OffW     = $clog2(NumBytes);
  localparam int unsigned IdxW     = $clog2(`TCDM_MEM_WORDS);

  logic [DataW-1:0] mem [`TCDM_MEM_WORDS];
  logic [IdxW-1:0]  word_idx;
  logic [DataW-1:0] old_word;
  logic [DataW-1:0] new_word;
  logic [DataW-1:0] rdata_q;
  logic             rvalid_q;
  logic             wr_en;

  assign word_idx = tcdm_req_i.q.addr[OffW +: IdxW];
  assign old_word = mem[word_idx];
  assign wr_en    = tcdm_req_i.q_valid & (tcdm_req_i.q.write | (tcdm_req_i.q.amo != AmoNone));

  always_comb begin
    new_word = old_word;
    case (tcdm_req_i.q.amo)
      AmoSwap: new_word = tcdm_req_i.q.data;
      AmoAdd:  new_word = old_word + tcdm_req_i.q.data;  // wraps at the word width
      default: begin
        for (int unsigned b = 0; b < NumBytes; b++) begin
          if (tcdm_req_i.q.strb[b]) begin
            new_word[8*b +: 8] = tcdm_req_i.q.data[8*b +: 8];
          end
        end
      end
    endcase
  end

  // every access returns the word as it was before the accepting edge
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[word_idx] <= new_word;
    end
    if (tcdm_req_i.q_valid) begin
      rdata_q <= old_word;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= tcdm_req_i.q_valid;
    end
  end

  assign tcdm_rsp_o.p_data  = rdata_q;
  assign tcdm_rsp_o.p_valid = rvalid_q;
  assign tcdm_rsp_o.q_ready = 1'b1;  // never stalls

endmodule

//--- verilog/reqrsp_tcdm_top.sv
//****************************************
// reqrsp_tcdm_top
// converters, arbiter and shared bank
//****************************************

`timescale 1ns/100ps

`include "tcdm_defs.svh"

module reqrsp_tcdm_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  reqrsp_pkg::reqrsp_req_t reqrsp_req_i [`TCDM_NUM_MASTERS],
  output reqrsp_pkg::reqrsp_rsp_t reqrsp_rsp_o [`TCDM_NUM_MASTERS]
);

  import tcdm_pkg::*;

  tcdm_req_t mst_req [`TCDM_NUM_MASTERS];
  tcdm_rsp_t mst_rsp [`TCDM_NUM_MASTERS];
  tcdm_req_t bank_req;
  tcdm_rsp_t bank_rsp;

  for (genvar m = 0; m < `TCDM_NUM_MASTERS; m++) begin : g_conv
    reqrsp_to_tcdm u_conv (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .reqrsp_req_i (reqrsp_req_i[m]),
      .reqrsp_rsp_o (reqrsp_rsp_o[m]),
      .tcdm_req_o   (mst_req[m]),
      .tcdm_rsp_i   (mst_rsp[m])
    );
  end

  tcdm_arbiter u_arb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .mst_req_i  (mst_req),
    .mst_rsp_o  (mst_rsp),
    .bank_req_o (bank_req),
    .bank_rsp_i (bank_rsp)
  );

  tcdm_bank u_bank (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .tcdm_req_i (bank_req),
    .tcdm_rsp_o (bank_rsp)
  );

endmodule

//--- bench/tb_reqrsp_tcdm.sv
//****************************************
// tb_reqrsp_tcdm
// random two-master traffic on the tcdm
// subsystem, checked against a memory model
//****************************************

`timescale 1ns/100ps

`include "tcdm_defs.svh"

module tb_reqrsp_tcdm;

  import reqrsp_pkg::*;

  localparam int unsigned NumMst     = `TCDM_NUM_MASTERS;
  localparam int unsigned NumTxn     = 200;  // requests per master including the fill writes
  localparam int unsigned NumWords   = 16;   // small window so the masters collide
  localparam int unsigned TxnCycles  = 10;
  localparam int unsigned BurstStart = 40;
  localparam int unsigned StallStart = 160;
  localparam int unsigned StallLen   = 40;
  localparam int unsigned TimeoutNs  = (NumMst * NumTxn * TxnCycles + StallLen + 200) * 8;

  logic                        clk;
  logic                        rst_n;
  reqrsp_req_t                 req [NumMst];
  reqrsp_rsp_t                 rsp [NumMst];
  logic [`TCDM_DATA_WIDTH-1:0] model_mem [NumWords];
  logic [`TCDM_DATA_WIDTH:0]   exp_q [NumMst][$];  // top bit set when the data is compared
  logic [15:0]                 lfsr;
  logic                        q_fire [NumMst];
  logic                        p_fire [NumMst];
  int unsigned                 issued [NumMst];
  int unsigned                 cycle;
  int unsigned                 stall_served;
  logic                        stalled;

  reqrsp_tcdm_top u_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .reqrsp_req_i (req),
    .reqrsp_rsp_o (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(TimeoutNs);
    abort_run("timeout, not every request got its response in time");
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic expect_equal(input string name, input logic [31:0] act,
                              input logic [31:0] exp);
    if (act !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, act, exp));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  task automatic take_bits(input int unsigned n, output logic [31:0] bits);
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  function automatic logic all_done();
    for (int unsigned m = 0; m < NumMst; m++) begin
      if (issued[m] < NumTxn || exp_q[m].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic drive_master(input int unsigned m);
    logic [31:0]                 r;
    logic [31:0]                 data;
    logic [1:0]                  op;
    logic                        want;
    logic [`TCDM_ADDR_WIDTH-1:0] addr;
    amo_op_e                     amo;
    take_bits(2, r);
    req[m].p_ready <= (m == 1 && stalled) ? 1'b0 : (r[1:0] != 2'b00);
    if (!req[m].q_valid || q_fire[m]) begin  // a pending request keeps its payload
      addr = '0;
      if (issued[m] >= NumTxn || (m == 1 && issued[0] < NumWords)) begin
        req[m].q_valid <= 1'b0;
      end else if (m == 0 && issued[0] < NumWords) begin
        // master 0 fills the window once so no read sees an unwritten word
        take_bits(32, data);
        addr[5:2] = 4'(issued[0]);
        req[m].q       <= '{addr: addr, write: 1'b1, amo: AmoNone, data: data, strb: 4'hf};
        req[m].q_valid <= 1'b1;
      end else begin
        take_bits(2, r);
        want = (cycle >= BurstStart && cycle < StallStart) || (r[1:0] != 2'b00);
        take_bits(2, r);
        op = r[1:0];  // read, write, swap, add
        take_bits(4, r);
        addr[5:2] = r[3:0];
        take_bits(32, data);
        take_bits(4, r);
        amo = (op == 2'd2) ? AmoSwap : (op == 2'd3) ? AmoAdd : AmoNone;
        req[m].q <= '{addr: addr, write: (op == 2'd1), amo: amo, data: data,
                      strb: (op == 2'd1) ? r[3:0] : 4'hf};
        req[m].q_valid <= want;
      end
    end
  endtask

  task automatic model_request(input int unsigned m);
    reqrsp_q_t   q;
    logic [3:0]  idx;
    logic [31:0] old_word;
    logic [31:0] new_word;
    q        = req[m].q;
    idx      = q.addr[5:2];
    old_word = model_mem[idx];
    new_word = old_word;
    if (q.amo == AmoSwap) begin
      new_word = q.data;
    end else if (q.amo == AmoAdd) begin
      new_word = old_word + q.data;
    end else if (q.write) begin
      for (int unsigned b = 0; b < 4; b++) begin
        if (q.strb[b]) begin
          new_word[8*b +: 8] = q.data[8*b +: 8];
        end
      end
    end
    model_mem[idx] = new_word;
    // plain writes return nothing the masters rely on
    exp_q[m].push_back({(q.amo != AmoNone) || !q.write, old_word});
    issued[m]++;
  endtask

  // outputs are settled half a cycle after the driving edge
  always @(negedge clk) begin
    logic [`TCDM_DATA_WIDTH:0] entry;
    if (rst_n) begin
      for (int unsigned m = 0; m < NumMst; m++) begin
        p_fire[m] = rsp[m].p_valid && req[m].p_ready;
        q_fire[m] = req[m].q_valid && rsp[m].q_ready;
      end
      if (q_fire[0] && q_fire[1]) begin
        abort_run("both masters transferred a request in the same cycle");
      end
      for (int unsigned m = 0; m < NumMst; m++) begin
        if (p_fire[m]) begin
          if (exp_q[m].size() == 0) begin
            abort_run($sformatf("master %0d got a response with no request pending", m));
          end else begin
            entry = exp_q[m].pop_front();
            if (entry[`TCDM_DATA_WIDTH]) begin
              expect_equal($sformatf("p.data[%0d]", m), rsp[m].p.data, entry[31:0]);
            end
          end
        end
        if (q_fire[m]) begin
          model_request(m);
        end
        if (exp_q[m].size() > `TCDM_BUF_DEPTH) begin
          abort_run($sformatf("master %0d has more requests in flight than it can buffer",
                              m));
        end
      end
      if (stalled && p_fire[0]) begin
        stall_served++;
      end
    end
  end

  initial begin
    lfsr         = 16'd81;
    cycle        = 0;
    stall_served = 0;
    stalled      = 1'b0;
    for (int unsigned m = 0; m < NumMst; m++) begin
      req[m]    = '0;
      issued[m] = 0;
      q_fire[m] = 1'b0;
      p_fire[m] = 1'b0;
    end
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    for (int unsigned m = 0; m < NumMst; m++) begin
      expect_equal($sformatf("p_valid[%0d]", m), 32'(rsp[m].p_valid), 32'd0);
    end
    while (!all_done()) begin
      @(posedge clk);
      cycle++;
      stalled = (cycle >= StallStart) && (cycle < StallStart + StallLen);
      for (int unsigned m = 0; m < NumMst; m++) begin
        drive_master(m);
      end
    end
    if (stall_served == 0) begin
      abort_run("master 0 got no response while master 1 held p_ready low");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

//--- reqrsp_tcdm.f
+incdir+common
common/reqrsp_pkg.sv
common/tcdm_pkg.sv
reqrsp_to_tcdm/reqrsp_to_tcdm.sv
verilog/tcdm_arbiter.sv
verilog/tcdm_bank.sv
verilog/reqrsp_tcdm_top.sv
bench/tb_reqrsp_tcdm.sv
